//--- Bender.yml
package:
  name: arcade_input

sources:
  - logic/mcr3_input_pkg.sv
  - logic/host_config.sv
  - logic/key_decoder.sv
  - logic/control_merge.sv
  - logic/port_mapper.sv
  - logic/arcade_input_top.sv
  - target: simulation
    files:
      - verification/arcade_input_checker.sv
      - verification/tb_arcade_input.sv

//--- logic/arcade_input_top.sv
// Player input controller top level
// Host config, key decoder, control merge and port mapper

module arcade_input_top
	import mcr3_input_pkg::*;
#(
	parameter int NUM_DIP_BYTES = 8
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  key_event_t        key,
	input  player_ctrl_t      joy1,
	input  player_ctrl_t      joy2,
	input  player_ctrl_t      joy3,
	input  cfg_write_t        cfg,
	input  logic [2:0]        fly_fire,       // One per player
	input  logic              snd_stat,
	input  logic              player_select,  // Board output latch bit
	input  logic              rd_req,
	input  port_sel_t         rd_sel,
	output logic              rd_ack,
	output logic [PORT_W-1:0] rd_data
);

	game_t        game;
	logic [7:0]   dip0;
	logic [7:0]   dip1;
	player_ctrl_t kbd1;
	player_ctrl_t kbd2;
	logic [1:0]   kbd_coins;
	player_ctrl_t p1;
	player_ctrl_t p2;
	player_ctrl_t p3;
	logic [2:0]   gear;

	host_config #(
		.NUM_DIP_BYTES(NUM_DIP_BYTES)
	) u_host_config (
		.clk_sys(clk_sys),
		.reset(reset),
		.cfg(cfg),
		.game(game),
		.dip0(dip0),
		.dip1(dip1)
	);

	key_decoder u_key_decoder (
		.clk_sys(clk_sys),
		.reset(reset),
		.key(key),
		.kbd1(kbd1),
		.kbd2(kbd2),
		.kbd_coins(kbd_coins)
	);

	control_merge u_control_merge (
		.clk_sys(clk_sys),
		.reset(reset),
		.game(game),
		.kbd1(kbd1),
		.kbd2(kbd2),
		.kbd_coins(kbd_coins),
		.joy1(joy1),
		.joy2(joy2),
		.joy3(joy3),
		.p1(p1),
		.p2(p2),
		.p3(p3),
		.gear(gear)
	);

	port_mapper u_port_mapper (
		.clk_sys(clk_sys),
		.reset(reset),
		.game(game),
		.dip0(dip0),
		.dip1(dip1),
		.p1(p1),
		.p2(p2),
		.p3(p3),
		.gear(gear),
		.fly_fire(fly_fire),
		.snd_stat(snd_stat),
		.player_select(player_select),
		.rd_req(rd_req),
		.rd_sel(rd_sel),
		.rd_ack(rd_ack),
		.rd_data(rd_data)
	);

endmodule

//--- logic/control_merge.sv
// Keyboard and joystick merge for three players
// Per-game coin routing
// Gear toggles driven by fire_d edges

module control_merge
	import mcr3_input_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  game_t        game,
	input  player_ctrl_t kbd1,
	input  player_ctrl_t kbd2,
	input  logic [1:0]   kbd_coins,
	input  player_ctrl_t joy1,
	input  player_ctrl_t joy2,
	input  player_ctrl_t joy3,
	output player_ctrl_t p1,
	output player_ctrl_t p2,
	output player_ctrl_t p3,
	output logic [2:0]   gear
);

	logic       own_coins;     // Separate coin slots per player
	logic       shared_coin;
	logic [2:0] fire_d_now;
	logic [2:0] fire_d_q;

	assign own_coins = (game == GAME_POWERDRIVE) || (game == GAME_STARGRDS);

	// Any coin at all, for the single-slot games
	assign shared_coin = kbd1.coin | kbd_coins[0] | kbd_coins[1]
	                   | joy1.coin | joy2.coin | joy3.coin;

	//==========================================================================
	// Player controls
	//==========================================================================
	always_comb begin
		p1 = player_ctrl_t'(kbd1 | joy1);
		p2 = player_ctrl_t'(kbd2 | joy2);
		p3 = joy3;                       // Joystick only

		if (own_coins) begin
			p1.coin = kbd1.coin | joy1.coin;
			p2.coin = kbd_coins[0] | joy2.coin;
			p3.coin = joy3.coin;
		end else begin
			p1.coin = shared_coin;
			p2.coin = 1'b0;
			p3.coin = 1'b0;
		end
	end

	//==========================================================================
	// Gear toggles
	//==========================================================================
	assign fire_d_now = {p3.fire_d, p2.fire_d, p1.fire_d};

	always_ff @(posedge clk_sys) begin
		fire_d_q <= fire_d_now;          // Held button after reset gives no toggle

		if (reset)
			gear <= '0;
		else
			gear <= gear ^ (fire_d_now & ~fire_d_q);  // Flip on rising edge
	end

endmodule

//--- logic/host_config.sv
// Host loader configuration capture
// Game select register with decoded game output
// DIP switch bank, bytes 0 and 1 exported

module host_config
	import mcr3_input_pkg::*;
#(
	parameter int NUM_DIP_BYTES = 8
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  cfg_write_t cfg,
	output game_t      game,
	output logic [7:0] dip0,
	output logic [7:0] dip1
);

	logic [7:0] game_code;                    // As loaded, unchecked
	logic [7:0] dip_bank [NUM_DIP_BYTES];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_code <= 8'hFF;               // No game until the loader says so
			game      <= game_t'(8'hFF);
		end else begin
			if (cfg.wr && cfg.index == CFG_INDEX_GAME)
				game_code <= cfg.data;
			game <= game_t'(game_code);       // One edge behind the write
		end
	end

	// Writes beyond the bank depth are dropped
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < NUM_DIP_BYTES; i++)
				dip_bank[i] <= 8'hFF;
		end else if (cfg.wr && cfg.index == CFG_INDEX_DIP && int'(cfg.addr) < NUM_DIP_BYTES) begin
			dip_bank[cfg.addr] <= cfg.data;
		end
	end

	assign dip0 = dip_bank[0];
	assign dip1 = dip_bank[1];

endmodule

//--- logic/key_decoder.sv
// PS/2 key event decoder
// Held buttons for keyboard players 1 and 2
// Extra coin keys for coins 2 and 3

module key_decoder
	import mcr3_input_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  key_event_t   key,
	output player_ctrl_t kbd1,
	output player_ctrl_t kbd2,
	output logic [1:0]   kbd_coins   // {coin3, coin2}
);

	logic toggle_q;
	logic new_event;

	assign new_event = (key.toggle != toggle_q);

	always_ff @(posedge clk_sys) begin
		toggle_q <= key.toggle;        // Tracks through reset, no stale event

		if (reset) begin
			kbd1      <= '0;
			kbd2      <= '0;
			kbd_coins <= '0;
		end else if (new_event) begin
			case (key.code)
				// Player 1
				KEY_UP:                     kbd1.up     <= key.pressed;
				KEY_DOWN:                   kbd1.down   <= key.pressed;
				KEY_LEFT:                   kbd1.left   <= key.pressed;
				KEY_RIGHT:                  kbd1.right  <= key.pressed;
				KEY_FIRE_A:                 kbd1.fire_a <= key.pressed;
				KEY_FIRE_B:                 kbd1.fire_b <= key.pressed;
				KEY_FIRE_C:                 kbd1.fire_c <= key.pressed;
				KEY_FIRE_D:                 kbd1.fire_d <= key.pressed;
				KEY_START1, KEY_START1_ALT: kbd1.start  <= key.pressed;
				KEY_COIN1, KEY_COIN1_ALT:   kbd1.coin   <= key.pressed;

				// Player 2, coin goes through kbd_coins
				KEY_UP2:                    kbd2.up     <= key.pressed;
				KEY_DOWN2:                  kbd2.down   <= key.pressed;
				KEY_LEFT2:                  kbd2.left   <= key.pressed;
				KEY_RIGHT2:                 kbd2.right  <= key.pressed;
				KEY_FIRE2_A:                kbd2.fire_a <= key.pressed;
				KEY_FIRE2_B:                kbd2.fire_b <= key.pressed;
				KEY_FIRE2_C:                kbd2.fire_c <= key.pressed;
				KEY_FIRE2_D:                kbd2.fire_d <= key.pressed;
				KEY_START2, KEY_START2_ALT: kbd2.start  <= key.pressed;

				KEY_COIN2:                  kbd_coins[0] <= key.pressed;
				KEY_COIN3:                  kbd_coins[1] <= key.pressed;
				default: ;                  // Unmapped key
			endcase
		end
	end

endmodule

//--- logic/mcr3_input_pkg.sv
// Shared definitions of the arcade input controller
// Board variant enum, player control and key event structs,
// host config write struct, PS/2 scan codes and port constants

package mcr3_input_pkg;

	//==========================================================================
	// Board variants
	//==========================================================================
	// Codes not listed here fall back to the default port image
	typedef enum logic [7:0] {
		GAME_RAMPAGE    = 8'd0,
		GAME_SARGE      = 8'd1,
		GAME_POWERDRIVE = 8'd2,
		GAME_STARGRDS   = 8'd5
	} game_t;

	//==========================================================================
	// Control words
	//==========================================================================
	// Same bit order as the joystick word, right in bit 0
	typedef struct packed {
		logic coin;    // bit 9
		logic start;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;   // bit 0
	} player_ctrl_t;

	typedef struct packed {
		logic       toggle;  // Flips on every new event
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic       wr;
		logic [7:0] index;
		logic [2:0] addr;
		logic [7:0] data;
	} cfg_write_t;

	// Loader indexes
	localparam logic [7:0] CFG_INDEX_GAME = 8'd1;
	localparam logic [7:0] CFG_INDEX_DIP  = 8'd254;

	//==========================================================================
	// PS/2 set 2 scan codes
	//==========================================================================
	localparam logic [7:0] KEY_UP         = 8'h75;
	localparam logic [7:0] KEY_DOWN       = 8'h72;
	localparam logic [7:0] KEY_LEFT       = 8'h6B;
	localparam logic [7:0] KEY_RIGHT      = 8'h74;
	localparam logic [7:0] KEY_COIN1      = 8'h76; // Esc
	localparam logic [7:0] KEY_START1     = 8'h05; // F1
	localparam logic [7:0] KEY_START2     = 8'h06; // F2
	localparam logic [7:0] KEY_FIRE_A     = 8'h14; // Left Ctrl
	localparam logic [7:0] KEY_FIRE_B     = 8'h11; // Left Alt
	localparam logic [7:0] KEY_FIRE_C     = 8'h29; // Space
	localparam logic [7:0] KEY_FIRE_D     = 8'h12; // Left Shift
	localparam logic [7:0] KEY_START1_ALT = 8'h16; // 1
	localparam logic [7:0] KEY_START2_ALT = 8'h1E; // 2
	localparam logic [7:0] KEY_COIN1_ALT  = 8'h2E; // 5
	localparam logic [7:0] KEY_COIN2      = 8'h36; // 6
	localparam logic [7:0] KEY_COIN3      = 8'h3D; // 7
	localparam logic [7:0] KEY_UP2        = 8'h2D; // R
	localparam logic [7:0] KEY_DOWN2      = 8'h2B; // F
	localparam logic [7:0] KEY_LEFT2      = 8'h23; // D
	localparam logic [7:0] KEY_RIGHT2     = 8'h34; // G
	localparam logic [7:0] KEY_FIRE2_A    = 8'h1C; // A
	localparam logic [7:0] KEY_FIRE2_B    = 8'h1B; // S
	localparam logic [7:0] KEY_FIRE2_C    = 8'h15; // Q
	localparam logic [7:0] KEY_FIRE2_D    = 8'h1D; // W

	// Game input ports
	localparam int NUM_PORTS = 5;
	localparam int PORT_W    = 8;
	typedef logic [2:0] port_sel_t;

endpackage

//--- logic/port_mapper.sv
// Game input port builder
// Per-variant mapping of the five 8-bit active-low ports
// Four-phase req/ack read port for the board CPU

module port_mapper
	import mcr3_input_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  game_t             game,
	input  logic [7:0]        dip0,
	input  logic [7:0]        dip1,
	input  player_ctrl_t      p1,
	input  player_ctrl_t      p2,
	input  player_ctrl_t      p3,
	input  logic [2:0]        gear,
	input  logic [2:0]        fly_fire,
	input  logic              snd_stat,
	input  logic              player_select,
	input  logic              rd_req,
	input  port_sel_t         rd_sel,
	output logic              rd_ack,
	output logic [PORT_W-1:0] rd_data
);

	logic [PORT_W-1:0] port_val [NUM_PORTS];
	logic              sel_start;   // Start/coin of player 2 or 3 on the shared bits
	logic              sel_coin;

	//==========================================================================
	// Per-player bit groups
	//==========================================================================
	// Fire b, fire a, left, down, right, up
	function automatic logic [5:0] four_way(input player_ctrl_t p);
		return {p.fire_b, p.fire_a, p.left, p.down, p.right, p.up};
	endfunction

	// Twin-stick emulation, returns {rd, ru, ld, lu}
	function automatic logic [3:0] twin_stick(input player_ctrl_t p, input logic stick);
		logic lu;
		logic ld;
		logic ru;
		logic rd;
		if (stick) begin
			lu = p.up | p.right;
			ld = p.down | p.left;
			ru = p.up | p.left;
			rd = p.down | p.right;
		end else begin
			lu = p.up;
			ld = p.down;
			ru = p.fire_c;
			rd = p.fire_b;
		end
		return {rd, ru, ld, lu};
	endfunction

	// Directions on top, fires or fly+fire below
	function automatic logic [7:0] fly_port(input player_ctrl_t p, input logic fly);
		logic [3:0] dirs;
		logic [3:0] fires;
		dirs  = {p.right, p.left, p.down, p.up};
		fires = {p.fire_a, p.fire_d, p.fire_b, p.fire_c};
		if (fly)
			return {dirs, (|fires) ? dirs : 4'b0000};
		return {dirs, fires};
	endfunction

	//==========================================================================
	// Port images
	//==========================================================================
	assign sel_start = player_select ? p3.start : p2.start;
	assign sel_coin  = player_select ? p3.coin  : p2.coin;

	always_comb begin
		port_val[0] = '1;
		port_val[1] = '1;
		port_val[2] = '1;
		port_val[3] = dip0;                 // Same for every game
		port_val[4] = '1;

		case (game)
			GAME_RAMPAGE: begin
				port_val[0] = ~{2'b00, dip1[0], 1'b0, 2'b00, p2.coin, p1.coin};
				port_val[1] = ~{2'b00, four_way(p1)};
				port_val[2] = ~{2'b00, four_way(p2)};
				port_val[4] = ~{snd_stat, 1'b0, four_way(p3)};
			end
			GAME_SARGE: begin
				port_val[0] = ~{2'b00, dip1[0], 1'b0, p2.start, p1.start, p2.coin, p1.coin};
				port_val[1] = ~{p1.fire_d, p1.fire_d, p1.fire_a, p1.fire_a,
				                twin_stick(p1, fly_fire[0])};
				port_val[2] = ~{p2.fire_d, p2.fire_d, p2.fire_a, p2.fire_a,
				                twin_stick(p2, fly_fire[0])};
			end
			GAME_POWERDRIVE: begin
				port_val[0] = ~{2'b00, dip1[0], 2'b00, p3.coin, p2.coin, p1.coin};
				port_val[1] = ~{p2.fire_b, p2.fire_a, gear[1], p2.fire_c,
				                p1.fire_b, p1.fire_a, gear[0], p1.fire_c};
				port_val[2] = ~{snd_stat, 3'b000, p3.fire_b, p3.fire_a, gear[2], p3.fire_c};
			end
			GAME_STARGRDS: begin
				port_val[0] = ~{dip1[0], 2'b00, snd_stat, sel_start, p1.start, sel_coin, p1.coin};
				port_val[1] = ~fly_port(p1, fly_fire[0]);
				port_val[2] = ~fly_port(p2, fly_fire[1]);
				port_val[4] = ~fly_port(p3, fly_fire[2]);
			end
			default: ;                          // Unsupported game, idle image
		endcase
	end

	//==========================================================================
	// Read handshake
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_ack <= 1'b0;
		end else if (rd_req && !rd_ack) begin
			rd_ack <= 1'b1;
		end else if (!rd_req && rd_ack) begin
			rd_ack <= 1'b0;                 // Ready for the next request
		end
	end

	// Data captured once per request, held while ack is up
	always_ff @(posedge clk_sys) begin
		if (rd_req && !rd_ack)
			rd_data <= (int'(rd_sel) < NUM_PORTS) ? port_val[rd_sel] : '1;
	end

endmodule

//--- verification/arcade_input_checker.sv
// Read handshake assertions for the port mapper
// Reset state, ack rise and fall, data hold while acked

module arcade_input_checker
	import mcr3_input_pkg::*;
(
	input logic              clk_sys,
	input logic              reset,
	input logic              rd_req,
	input logic              rd_ack,
	input logic [PORT_W-1:0] rd_data
);
	timeunit 1ns;
	timeprecision 100ps;

	ack_low_after_reset: assert property (@(posedge clk_sys) reset |=> !rd_ack)
		else $error("rd_ack high after a reset cycle");

	ack_rises: assert property (@(posedge clk_sys) disable iff (reset)
		(rd_req && !rd_ack) |=> rd_ack)
		else $error("rd_ack did not rise one cycle after rd_req");

	// No new capture while the ack is up
	data_holds: assert property (@(posedge clk_sys) disable iff (reset)
		rd_ack |=> $stable(rd_data))
		else $error("rd_data changed while rd_ack was high");

	ack_falls: assert property (@(posedge clk_sys) disable iff (reset)
		(rd_ack && !rd_req) |=> !rd_ack)
		else $error("rd_ack did not fall after rd_req dropped");

endmodule

//--- verification/tb_arcade_input.sv
// Testbench for the arcade input controller
// Random keys, joysticks and config per game against a port model
// Gear toggles, reset and read handshake checks

module tb_arcade_input
	import mcr3_input_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DIP_BYTES   = 8;
	localparam int NUM_STEPS   = 30;
	localparam int GEAR_PULSES = 8;
	localparam int NUM_READS   = 6 * NUM_STEPS * NUM_PORTS + 2 * GEAR_PULSES + 2;
	localparam int CYCLE_LIMIT = 20 * NUM_READS + 2000;

	logic              clk_sys;
	logic              reset;
	key_event_t        key;
	player_ctrl_t      joy1;
	player_ctrl_t      joy2;
	player_ctrl_t      joy3;
	cfg_write_t        cfg;
	logic [2:0]        fly_fire;
	logic              snd_stat;
	logic              player_select;
	logic              rd_req;
	port_sel_t         rd_sel;
	logic              rd_ack;
	logic [PORT_W-1:0] rd_data;

	logic [21:0] kbv;               // Held keys {coin3, coin2, kbd2, kbd1}
	logic [7:0]  m_game;
	logic [7:0]  m_dip [DIP_BYTES];
	logic [2:0]  m_gear;
	logic [2:0]  m_prev_fd;
	integer      seed = 32'h20b5;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	// Scan code and its bit in kbv, -1 for a key nobody uses
	logic [7:0] key_codes [25] = '{KEY_RIGHT, KEY_LEFT, KEY_DOWN, KEY_UP, KEY_FIRE_A,
		KEY_FIRE_B, KEY_FIRE_C, KEY_FIRE_D, KEY_START1, KEY_COIN1, KEY_RIGHT2, KEY_LEFT2,
		KEY_DOWN2, KEY_UP2, KEY_FIRE2_A, KEY_FIRE2_B, KEY_FIRE2_C, KEY_FIRE2_D, KEY_START2,
		KEY_COIN2, KEY_COIN3, KEY_START1_ALT, KEY_COIN1_ALT, KEY_START2_ALT, 8'h00};
	int key_bits [25] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 18,
		20, 21, 8, 9, 18, -1};
	logic [7:0] games [6] = '{8'd0, 8'd1, 8'd2, 8'd5, 8'd3, 8'd4};

	arcade_input_top #(.NUM_DIP_BYTES(DIP_BYTES)) uut (.*);

	bind port_mapper arcade_input_checker u_checker (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		wait_cycles(16);
		reset  = 1'b0;
		kbv    = '0;
		m_gear = '0;
		m_game = 8'hFF;
		foreach (m_dip[i])
			m_dip[i] = 8'hFF;
		m_prev_fd = {joy3.fire_d, joy2.fire_d, joy1.fire_d};  // Edge detect runs through reset
	endtask

	task automatic cfg_write(input logic [7:0] index, input logic [2:0] addr,
	                         input logic [7:0] data);
		cfg = '{1'b1, index, addr, data};
		wait_cycles(1);
		cfg.wr = 1'b0;
		if (index == CFG_INDEX_GAME)
			m_game = data;
		else if (index == CFG_INDEX_DIP)
			m_dip[addr] = data;
	endtask

	// Call after each change that reaches the merged fire_d
	task automatic track_gear();
		logic [2:0] fd;
		fd = {joy3.fire_d, kbv[17] | joy2.fire_d, kbv[7] | joy1.fire_d};
		m_gear    = m_gear ^ (fd & ~m_prev_fd);
		m_prev_fd = fd;
	endtask

	//==========================================================================
	// Port model
	//==========================================================================
	function automatic logic [7:0] expect_port(input int sel);
		player_ctrl_t pl [3];
		player_ctrl_t pp;
		logic         own;
		logic [3:0]   dirs;
		logic [3:0]   fires;
		logic [7:0]   v;
		own   = (m_game == 8'd2) || (m_game == 8'd5);
		pl[0] = player_ctrl_t'(kbv[9:0] | joy1);
		pl[1] = player_ctrl_t'(kbv[19:10] | joy2);
		pl[2] = joy3;
		pl[0].coin = kbv[9] | joy1.coin | (!own & (kbv[20] | kbv[21] | joy2.coin | joy3.coin));
		pl[1].coin = own & (kbv[20] | joy2.coin);
		pl[2].coin = own & joy3.coin;
		pp    = pl[(sel == 4) ? 2 : (sel == 0) ? 0 : sel - 1];
		dirs  = {pp.right, pp.left, pp.down, pp.up};
		fires = {pp.fire_a, pp.fire_d, pp.fire_b, pp.fire_c};
		v     = 8'h00;                  // Active high here, inverted on return
		if (sel == 3)
			return m_dip[0];
		case (m_game)
			8'd0: begin
				if (sel == 0)
					v = {2'b00, m_dip[1][0], 3'b000, pl[1].coin, pl[0].coin};
				else
					v = {(sel == 4) && snd_stat, 1'b0, pp.fire_b, pp.fire_a,
					     pp.left, pp.down, pp.right, pp.up};
			end
			8'd1: begin
				if (sel == 0)
					v = {2'b00, m_dip[1][0], 1'b0, pl[1].start, pl[0].start,
					     pl[1].coin, pl[0].coin};
				else if (sel != 4 && fly_fire[0])   // Stick mode
					v = {pp.fire_d, pp.fire_d, pp.fire_a, pp.fire_a, pp.down | pp.right,
					     pp.up | pp.left, pp.down | pp.left, pp.up | pp.right};
				else if (sel != 4)
					v = {pp.fire_d, pp.fire_d, pp.fire_a, pp.fire_a,
					     pp.fire_b, pp.fire_c, pp.down, pp.up};
			end
			8'd2: begin
				case (sel)
					0: v = {2'b00, m_dip[1][0], 2'b00, pl[2].coin, pl[1].coin, pl[0].coin};
					1: v = {pl[1].fire_b, pl[1].fire_a, m_gear[1], pl[1].fire_c,
					        pl[0].fire_b, pl[0].fire_a, m_gear[0], pl[0].fire_c};
					2: v = {snd_stat, 3'b000, pl[2].fire_b, pl[2].fire_a, m_gear[2],
					        pl[2].fire_c};
					default: ;
				endcase
			end
			8'd5: begin
				if (sel == 0)
					v = {m_dip[1][0], 2'b00, snd_stat, player_select ? pl[2].start : pl[1].start,
					     pl[0].start, player_select ? pl[2].coin : pl[1].coin, pl[0].coin};
				else if (fly_fire[(sel == 4) ? 2 : sel - 1])
					v = {dirs, (fires != 4'b0000) ? dirs : 4'b0000};
				else
					v = {dirs, fires};
			end
			default: ;                      // Unsupported code, all ports idle
		endcase
		return ~v;
	endfunction

	// Fresh joystick words and side inputs, gears follow any fire_d edge
	task automatic drive_random_inputs();
		joy1          = player_ctrl_t'($random(seed) & $random(seed));
		joy2          = player_ctrl_t'($random(seed) & $random(seed));
		joy3          = player_ctrl_t'($random(seed) & $random(seed));
		fly_fire      = $random(seed);
		snd_stat      = $random(seed);
		player_select = $random(seed);
		track_gear();
	endtask

	// New joystick words first, one key event on the next cycle
	task automatic random_step();
		int   i;
		logic pr;
		drive_random_inputs();
		wait_cycles(1);
		i   = $unsigned($random(seed)) % 25;
		pr  = $random(seed);
		key = '{~key.toggle, pr, key_codes[i]};
		if (key_bits[i] >= 0)
			kbv[key_bits[i]] = pr;
		track_gear();
		wait_cycles(3);
	endtask

	//==========================================================================
	// Four-phase read with value and hold checks
	//==========================================================================
	task automatic check_read(input int sel);
		logic [7:0] exp_val;
		logic [7:0] held;
		int         n;
		exp_val = expect_port(sel);
		rd_sel  = port_sel_t'(sel);
		rd_req  = 1'b1;
		n       = 0;
		do begin
			wait_cycles(1);
			n++;
		end while (!rd_ack && n < 8);
		checks++;
		if (n != 1) begin
			errors++;
			$display("Read of port %0d: rd_ack did not rise one cycle after rd_req", sel);
		end
		if (rd_data !== exp_val) begin
			errors++;
			$display("Error: rd_data port %0d game %02h expected %02h got %02h",
			         sel, m_game, exp_val, rd_data);
		end
		held = rd_data;
		repeat ($unsigned($random(seed)) % 4) begin   // Requester stalls
			drive_random_inputs();                      // Port inputs move under the held data
			wait_cycles(1);
			if (rd_data !== held || rd_ack !== 1'b1) begin
				errors++;
				$display("Error: rd_data not held, expected %02h got %02h, rd_ack %h",
				         held, rd_data, rd_ack);
			end
		end
		rd_req = 1'b0;
		wait_cycles(1);
		if (rd_ack !== 1'b0) begin
			errors++;
			$display("Read of port %0d: rd_ack still high after rd_req dropped", sel);
		end
	endtask

	initial begin
		int p;
		reset         = 1'b1;
		key           = '0;
		joy1          = '0;
		joy2          = '0;
		joy3          = '0;
		cfg           = '0;
		fly_fire      = '0;
		snd_stat      = 1'b0;
		player_select = 1'b0;
		rd_req        = 1'b0;
		rd_sel        = '0;
		apply_reset();

		// Each game gets fresh DIP bytes and one write with a foreign index
		foreach (games[gi]) begin
			for (int a = 0; a < DIP_BYTES; a++)
				cfg_write(CFG_INDEX_DIP, 3'(a), 8'($random(seed)));
			cfg_write(8'd2 + 8'($unsigned($random(seed)) % 100), 3'($random(seed)),
			          8'($random(seed)));
			cfg_write(CFG_INDEX_GAME, 3'd0, games[gi]);
			wait_cycles(2);
			repeat (NUM_STEPS) begin
				random_step();
				for (int s = 0; s < NUM_PORTS; s++)
					check_read(s);
			end
		end

		// Gear toggles in the driving game
		cfg_write(CFG_INDEX_GAME, 3'd0, 8'd2);
		wait_cycles(2);
		for (int g = 0; g < GEAR_PULSES; g++) begin
			p = $unsigned($random(seed)) % 3;
			{joy3.fire_d, joy2.fire_d, joy1.fire_d} = 3'b001 << p;
			track_gear();
			wait_cycles(2);
			{joy3.fire_d, joy2.fire_d, joy1.fire_d} = 3'b000;
			track_gear();
			wait_cycles(2);
			check_read(1);
			check_read(2);
		end

		// Gear 2 set, so the reset has a bit to clear
		if (!m_gear[2]) begin
			joy3.fire_d = 1'b0;
			track_gear();
			wait_cycles(1);
			joy3.fire_d = 1'b1;
			track_gear();
			wait_cycles(2);
		end
		apply_reset();
		cfg_write(CFG_INDEX_GAME, 3'd0, 8'd2);
		wait_cycles(2);
		check_read(1);
		check_read(2);

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- verilog.f
logic/mcr3_input_pkg.sv
logic/host_config.sv
logic/key_decoder.sv
logic/control_merge.sv
logic/port_mapper.sv
logic/arcade_input_top.sv
verification/arcade_input_checker.sv
verification/tb_arcade_input.sv
